//--- axi_sram_pkg.sv
// Single-beat AXI4 only; bursts, narrow sizes, exclusive access and prot/cache are not modelled
`default_nettype none

package axi_sram_pkg;

  // ----------------------------------------------------------------------
  // Bus widths and memory geometry
  // ----------------------------------------------------------------------
  localparam int ADDR_W    = 32;
  localparam int DATA_W    = 64;
  localparam int STRB_W    = DATA_W / 8;
  localparam int ID_W      = 4;
  localparam int MEM_DEPTH = 256;
  localparam int MEM_AW    = $clog2(MEM_DEPTH);
  // Byte offset bits inside one data word
  localparam int BYTE_AW   = $clog2(STRB_W);
  localparam int WIN_BYTES = MEM_DEPTH * STRB_W;

  // ----------------------------------------------------------------------
  // Encodings
  // ----------------------------------------------------------------------
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_RESP
  } wr_state_e;

  typedef enum logic {
    RD_IDLE,
    RD_DATA
  } rd_state_e;

  // CTRL data: bit 0 enable, bit 1 write-protect
  typedef enum logic {
    CFG_SET_BASE,
    CFG_SET_CTRL
  } cfg_op_e;

  // ----------------------------------------------------------------------
  // Channel payloads
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
    logic [2:0]        size;
    logic [1:0]        burst;
  } axi_aw_t;

  typedef axi_aw_t axi_ar_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
  } axi_w_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
    axi_resp_e       resp;
  } axi_b_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    axi_resp_e         resp;
    logic              last;
  } axi_r_t;

  typedef struct packed {
    cfg_op_e           op;
    logic [ADDR_W-1:0] data;
  } cfg_cmd_t;

endpackage

`default_nettype wire

//--- sram_array.sv
// Read data only changes on i_re; a same-cycle write to the read word returns the old data
`timescale 1ns/1ps
`default_nettype none

module sram_array (
  input  wire                                 i_aclk,
  input  wire                                 i_we,
  input  wire  [axi_sram_pkg::MEM_AW-1:0]     i_windex,
  input  wire  [axi_sram_pkg::DATA_W-1:0]     i_wdata,
  input  wire  [axi_sram_pkg::STRB_W-1:0]     i_wstrb,
  input  wire                                 i_re,
  input  wire  [axi_sram_pkg::MEM_AW-1:0]     i_rindex,
  output logic [axi_sram_pkg::DATA_W-1:0]     o_rdata
);

  logic [axi_sram_pkg::DATA_W-1:0] mem [axi_sram_pkg::MEM_DEPTH];

  // Byte lanes
  always_ff @(posedge i_aclk) begin
    if (i_we) begin
      for (int b = 0; b < axi_sram_pkg::STRB_W; b++) begin
        if (i_wstrb[b]) begin
          mem[i_windex][b*8 +: 8] <= i_wdata[b*8 +: 8];
        end
      end
    end
  end

  // Holds last read word while the R channel is stalled
  always_ff @(posedge i_aclk) begin
    if (i_re) begin
      o_rdata <= mem[i_rindex];
    end
  end

endmodule

`default_nettype wire

//--- axi_sram_window.sv
// Window is WIN_BYTES long from base; base must be word aligned; decode is purely combinational
`timescale 1ns/1ps
`default_nettype none

module axi_sram_window (
  input  wire                                 i_aclk,
  input  wire                                 i_reset,
  input  wire                                 i_cfg_stb,
  input  wire  axi_sram_pkg::cfg_cmd_t        i_cfg,
  input  wire  [axi_sram_pkg::ADDR_W-1:0]     i_wr_addr,
  output axi_sram_pkg::axi_resp_e             o_wr_resp,
  output logic [axi_sram_pkg::MEM_AW-1:0]     o_wr_index,
  input  wire  [axi_sram_pkg::ADDR_W-1:0]     i_rd_addr,
  output axi_sram_pkg::axi_resp_e             o_rd_resp,
  output logic [axi_sram_pkg::MEM_AW-1:0]     o_rd_index
);

  logic [axi_sram_pkg::ADDR_W-1:0] base_q;
  logic                            enable_q;
  logic                            protect_q;
  logic                            wr_hit;
  logic                            rd_hit;

  function automatic logic in_window(input logic [axi_sram_pkg::ADDR_W-1:0] addr,
                                     input logic [axi_sram_pkg::ADDR_W-1:0] base);
    logic [axi_sram_pkg::ADDR_W-1:0] offset;
    offset = addr - base;
    return (addr >= base) && (offset < axi_sram_pkg::WIN_BYTES);
  endfunction

  function automatic logic [axi_sram_pkg::MEM_AW-1:0] word_index(
      input logic [axi_sram_pkg::ADDR_W-1:0] addr,
      input logic [axi_sram_pkg::ADDR_W-1:0] base);
    logic [axi_sram_pkg::ADDR_W-1:0] offset;
    offset = addr - base;
    return offset[axi_sram_pkg::BYTE_AW +: axi_sram_pkg::MEM_AW];
  endfunction

  // ----------------------------------------------------------------------
  // Configuration registers
  // ----------------------------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (i_reset) begin
      base_q    <= '0;
      enable_q  <= 1'b0;
      protect_q <= 1'b0;
    end else if (i_cfg_stb) begin
      case (i_cfg.op)
        axi_sram_pkg::CFG_SET_BASE: begin
          base_q <= i_cfg.data;
        end
        axi_sram_pkg::CFG_SET_CTRL: begin
          enable_q  <= i_cfg.data[0];
          protect_q <= i_cfg.data[1];
        end
        default: begin
          base_q <= base_q;
        end
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // Decode, shared rule for both directions
  // ----------------------------------------------------------------------
  assign wr_hit     = enable_q && in_window(i_wr_addr, base_q);
  assign rd_hit     = enable_q && in_window(i_rd_addr, base_q);
  assign o_wr_index = word_index(i_wr_addr, base_q);
  assign o_rd_index = word_index(i_rd_addr, base_q);

  always_comb begin
    o_wr_resp = axi_sram_pkg::RESP_DECERR;
    if (wr_hit && protect_q) begin
      o_wr_resp = axi_sram_pkg::RESP_SLVERR;
    end else if (wr_hit) begin
      o_wr_resp = axi_sram_pkg::RESP_OKAY;
    end
  end

  always_comb begin
    o_rd_resp = axi_sram_pkg::RESP_DECERR;
    if (rd_hit) begin
      o_rd_resp = axi_sram_pkg::RESP_OKAY;
    end
  end

  // Misaligned base would shift every word across lanes
  a_base_aligned: assert property (@(posedge i_aclk) disable iff (i_reset)
    i_cfg_stb && (i_cfg.op == axi_sram_pkg::CFG_SET_BASE)
    |=> base_q[axi_sram_pkg::BYTE_AW-1:0] == '0);

endmodule

`default_nettype wire

//--- axi_sram_wr_ctrl.sv
// One write in flight; AWLEN must be 0 and WLAST set; size, burst and W ID are ignored
`timescale 1ns/1ps
`default_nettype none

module axi_sram_wr_ctrl (
  input  wire                                 i_aclk,
  input  wire                                 i_reset,
  input  wire  axi_sram_pkg::axi_aw_t         i_aw,
  input  wire                                 i_awvalid,
  output logic                                o_awready,
  input  wire  axi_sram_pkg::axi_w_t          i_w,
  input  wire                                 i_wvalid,
  output logic                                o_wready,
  output axi_sram_pkg::axi_b_t                o_b,
  output logic                                o_bvalid,
  input  wire                                 i_bready,
  output logic [axi_sram_pkg::ADDR_W-1:0]     o_wr_addr,
  input  wire  axi_sram_pkg::axi_resp_e       i_wr_resp,
  input  wire  [axi_sram_pkg::MEM_AW-1:0]     i_wr_index,
  output logic                                o_mem_we,
  output logic [axi_sram_pkg::MEM_AW-1:0]     o_mem_windex,
  output logic [axi_sram_pkg::DATA_W-1:0]     o_mem_wdata,
  output logic [axi_sram_pkg::STRB_W-1:0]     o_mem_wstrb
);

  axi_sram_pkg::wr_state_e         state_q;
  logic [axi_sram_pkg::ID_W-1:0]   id_q;
  logic [axi_sram_pkg::ADDR_W-1:0] addr_q;
  axi_sram_pkg::axi_resp_e         resp_q;
  logic                            aw_fire;
  logic                            w_fire;
  logic                            b_fire;

  assign o_awready = (state_q == axi_sram_pkg::WR_IDLE);
  assign o_wready  = (state_q == axi_sram_pkg::WR_DATA);
  assign o_bvalid  = (state_q == axi_sram_pkg::WR_RESP);

  assign aw_fire = i_awvalid & o_awready;
  assign w_fire  = i_wvalid & o_wready;
  assign b_fire  = o_bvalid & i_bready;

  always_ff @(posedge i_aclk) begin
    if (i_reset) begin
      state_q <= axi_sram_pkg::WR_IDLE;
    end else begin
      case (state_q)
        axi_sram_pkg::WR_IDLE: begin
          if (aw_fire) begin
            state_q <= axi_sram_pkg::WR_DATA;
          end
        end
        axi_sram_pkg::WR_DATA: begin
          if (w_fire) begin
            state_q <= axi_sram_pkg::WR_RESP;
          end
        end
        axi_sram_pkg::WR_RESP: begin
          if (b_fire) begin
            state_q <= axi_sram_pkg::WR_IDLE;
          end
        end
        default: begin
          state_q <= axi_sram_pkg::WR_IDLE;
        end
      endcase
    end
  end

  // Response is taken from the decode at the W beat
  always_ff @(posedge i_aclk) begin
    if (aw_fire) begin
      id_q   <= i_aw.id;
      addr_q <= i_aw.addr;
    end
    if (w_fire) begin
      resp_q <= i_wr_resp;
    end
  end

  assign o_wr_addr = addr_q;
  assign o_b       = '{id: id_q, resp: resp_q};

  // Protected and out-of-window writes leave memory untouched
  assign o_mem_we     = w_fire && (i_wr_resp == axi_sram_pkg::RESP_OKAY);
  assign o_mem_windex = i_wr_index;
  assign o_mem_wdata  = i_w.data;
  assign o_mem_wstrb  = i_w.strb;

  a_aw_single: assert property (@(posedge i_aclk) disable iff (i_reset)
    aw_fire |-> i_aw.len == 8'd0);

  a_w_last: assert property (@(posedge i_aclk) disable iff (i_reset)
    w_fire |-> i_w.last);

endmodule

`default_nettype wire

//--- axi_sram_rd_ctrl.sv
// One read in flight; ARLEN must be 0; size and burst are ignored, RLAST always set
`timescale 1ns/1ps
`default_nettype none

module axi_sram_rd_ctrl (
  input  wire                                 i_aclk,
  input  wire                                 i_reset,
  input  wire  axi_sram_pkg::axi_ar_t         i_ar,
  input  wire                                 i_arvalid,
  output logic                                o_arready,
  output axi_sram_pkg::axi_r_t                o_r,
  output logic                                o_rvalid,
  input  wire                                 i_rready,
  output logic [axi_sram_pkg::ADDR_W-1:0]     o_rd_addr,
  input  wire  axi_sram_pkg::axi_resp_e       i_rd_resp,
  input  wire  [axi_sram_pkg::MEM_AW-1:0]     i_rd_index,
  output logic                                o_mem_re,
  output logic [axi_sram_pkg::MEM_AW-1:0]     o_mem_rindex,
  input  wire  [axi_sram_pkg::DATA_W-1:0]     i_mem_rdata
);

  axi_sram_pkg::rd_state_e       state_q;
  logic [axi_sram_pkg::ID_W-1:0] id_q;
  axi_sram_pkg::axi_resp_e       resp_q;
  logic                          ar_fire;
  logic                          r_fire;
  logic [axi_sram_pkg::DATA_W-1:0] rdata;

  assign o_arready = (state_q == axi_sram_pkg::RD_IDLE);
  assign o_rvalid  = (state_q == axi_sram_pkg::RD_DATA);

  assign ar_fire = i_arvalid & o_arready;
  assign r_fire  = o_rvalid & i_rready;

  always_ff @(posedge i_aclk) begin
    if (i_reset) begin
      state_q <= axi_sram_pkg::RD_IDLE;
    end else if (ar_fire) begin
      state_q <= axi_sram_pkg::RD_DATA;
    end else if (r_fire) begin
      state_q <= axi_sram_pkg::RD_IDLE;
    end
  end

  always_ff @(posedge i_aclk) begin
    if (ar_fire) begin
      id_q   <= i_ar.id;
      resp_q <= i_rd_resp;
    end
  end

  // Array access issued in the AR cycle, data lands with rvalid
  assign o_rd_addr    = i_ar.addr;
  assign o_mem_re     = ar_fire;
  assign o_mem_rindex = i_rd_index;

  // Misses return zero data
  assign rdata = (resp_q == axi_sram_pkg::RESP_OKAY) ? i_mem_rdata : '0;
  assign o_r   = '{id: id_q, data: rdata, resp: resp_q, last: 1'b1};

  a_ar_single: assert property (@(posedge i_aclk) disable iff (i_reset)
    ar_fire |-> i_ar.len == 8'd0);

  // Array output must not move while the beat is stalled
  a_r_hold: assert property (@(posedge i_aclk) disable iff (i_reset)
    o_rvalid && !i_rready |=> o_rvalid && $stable(o_r));

endmodule

`default_nettype wire

//--- axi_sram_top.sv
// AXI4 slave over 2 KiB SRAM; single beats only, one write and one read outstanding
`timescale 1ns/1ps
`default_nettype none

module axi_sram_top (
  input  wire                                 i_aclk,
  input  wire                                 i_reset,
  input  wire                                 i_cfg_stb,
  input  wire  axi_sram_pkg::cfg_cmd_t        i_cfg,
  input  wire  axi_sram_pkg::axi_aw_t         i_aw,
  input  wire                                 i_awvalid,
  output wire                                 o_awready,
  input  wire  axi_sram_pkg::axi_w_t          i_w,
  input  wire                                 i_wvalid,
  output wire                                 o_wready,
  output wire  axi_sram_pkg::axi_b_t          o_b,
  output wire                                 o_bvalid,
  input  wire                                 i_bready,
  input  wire  axi_sram_pkg::axi_ar_t         i_ar,
  input  wire                                 i_arvalid,
  output wire                                 o_arready,
  output wire  axi_sram_pkg::axi_r_t          o_r,
  output wire                                 o_rvalid,
  input  wire                                 i_rready
);

  // ----------------------------------------------------------------------
  // Decode and array nets
  // ----------------------------------------------------------------------
  wire [axi_sram_pkg::ADDR_W-1:0] wr_addr;
  wire axi_sram_pkg::axi_resp_e   wr_resp;
  wire [axi_sram_pkg::MEM_AW-1:0] wr_index;
  wire [axi_sram_pkg::ADDR_W-1:0] rd_addr;
  wire axi_sram_pkg::axi_resp_e   rd_resp;
  wire [axi_sram_pkg::MEM_AW-1:0] rd_index;
  wire                            mem_we;
  wire [axi_sram_pkg::MEM_AW-1:0] mem_windex;
  wire [axi_sram_pkg::DATA_W-1:0] mem_wdata;
  wire [axi_sram_pkg::STRB_W-1:0] mem_wstrb;
  wire                            mem_re;
  wire [axi_sram_pkg::MEM_AW-1:0] mem_rindex;
  wire [axi_sram_pkg::DATA_W-1:0] mem_rdata;

  axi_sram_window u_window (
    .i_aclk     (i_aclk),     .i_reset    (i_reset),
    .i_cfg_stb  (i_cfg_stb),  .i_cfg      (i_cfg),
    .i_wr_addr  (wr_addr),    .o_wr_resp  (wr_resp),    .o_wr_index (wr_index),
    .i_rd_addr  (rd_addr),    .o_rd_resp  (rd_resp),    .o_rd_index (rd_index)
  );

  axi_sram_wr_ctrl u_wr_ctrl (
    .i_aclk       (i_aclk),       .i_reset      (i_reset),
    .i_aw         (i_aw),         .i_awvalid    (i_awvalid),   .o_awready (o_awready),
    .i_w          (i_w),          .i_wvalid     (i_wvalid),    .o_wready  (o_wready),
    .o_b          (o_b),          .o_bvalid     (o_bvalid),    .i_bready  (i_bready),
    .o_wr_addr    (wr_addr),      .i_wr_resp    (wr_resp),     .i_wr_index (wr_index),
    .o_mem_we     (mem_we),       .o_mem_windex (mem_windex),
    .o_mem_wdata  (mem_wdata),    .o_mem_wstrb  (mem_wstrb)
  );

  axi_sram_rd_ctrl u_rd_ctrl (
    .i_aclk       (i_aclk),       .i_reset      (i_reset),
    .i_ar         (i_ar),         .i_arvalid    (i_arvalid),   .o_arready (o_arready),
    .o_r          (o_r),          .o_rvalid     (o_rvalid),    .i_rready  (i_rready),
    .o_rd_addr    (rd_addr),      .i_rd_resp    (rd_resp),     .i_rd_index (rd_index),
    .o_mem_re     (mem_re),       .o_mem_rindex (mem_rindex),  .i_mem_rdata (mem_rdata)
  );

  sram_array u_sram (
    .i_aclk   (i_aclk),
    .i_we     (mem_we),
    .i_windex (mem_windex),
    .i_wdata  (mem_wdata),
    .i_wstrb  (mem_wstrb),
    .i_re     (mem_re),
    .i_rindex (mem_rindex),
    .o_rdata  (mem_rdata)
  );

endmodule

`default_nettype wire

//--- tb_axi_sram.sv
// Base stays 8-byte aligned and only words written earlier are read back; waits time out at 64 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_axi_sram;

  logic                                 aclk;
  logic                                 reset;
  logic                                 cfg_stb;
  axi_sram_pkg::cfg_cmd_t               cfg;
  axi_sram_pkg::axi_aw_t                aw;
  logic                                 awvalid;
  wire                                  awready;
  axi_sram_pkg::axi_w_t                 w;
  logic                                 wvalid;
  wire                                  wready;
  wire axi_sram_pkg::axi_b_t            b;
  wire                                  bvalid;
  logic                                 bready;
  axi_sram_pkg::axi_ar_t                ar;
  logic                                 arvalid;
  wire                                  arready;
  wire axi_sram_pkg::axi_r_t            r;
  wire                                  rvalid;
  logic                                 rready;

  // Reference model state
  logic [axi_sram_pkg::DATA_W-1:0]      model_mem [axi_sram_pkg::MEM_DEPTH];
  logic [axi_sram_pkg::ADDR_W-1:0]      model_base;
  logic                                 model_en;
  logic                                 model_prot;
  axi_sram_pkg::axi_b_t                 exp_b;
  axi_sram_pkg::axi_r_t                 exp_r;
  logic                                 wr_pending;
  logic                                 rd_pending;
  int                                   seed;
  int                                   errors;
  int                                   test_errors;
  int                                   tests;
  int                                   failed;
  string                                cur_name;
  int                                   written[$];

  axi_sram_top i_dut (
    .i_aclk    (aclk),    .i_reset   (reset),
    .i_cfg_stb (cfg_stb), .i_cfg     (cfg),
    .i_aw      (aw),      .i_awvalid (awvalid), .o_awready (awready),
    .i_w       (w),       .i_wvalid  (wvalid),  .o_wready  (wready),
    .o_b       (b),       .o_bvalid  (bvalid),  .i_bready  (bready),
    .i_ar      (ar),      .i_arvalid (arvalid), .o_arready (arready),
    .o_r       (r),       .o_rvalid  (rvalid),  .i_rready  (rready)
  );

  initial begin
    aclk = 1'b0;
    forever #20 aclk = ~aclk;
  end

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------
  function automatic axi_sram_pkg::axi_resp_e exp_resp(input logic [31:0] addr,
                                                        input logic is_write);
    logic [32:0] win_end;
    win_end = {1'b0, model_base} + axi_sram_pkg::WIN_BYTES;
    if (!model_en || addr < model_base || {1'b0, addr} >= win_end) begin
      return axi_sram_pkg::RESP_DECERR;
    end
    if (is_write && model_prot) begin
      return axi_sram_pkg::RESP_SLVERR;
    end
    return axi_sram_pkg::RESP_OKAY;
  endfunction

  function automatic int model_index(input logic [31:0] addr);
    return ((addr - model_base) / 8) % axi_sram_pkg::MEM_DEPTH;
  endfunction

  function automatic logic [63:0] exp_rdata(input logic [31:0] addr);
    if (exp_resp(addr, 1'b0) != axi_sram_pkg::RESP_OKAY) begin
      return '0;
    end
    return model_mem[model_index(addr)];
  endfunction

  function automatic logic [31:0] word_addr(input int idx);
    return model_base + idx * 8;
  endfunction

  function automatic logic [63:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic logic level_of(input string what);
    if (what == "awready") return awready;
    if (what == "wready") return wready;
    if (what == "bvalid") return bvalid;
    if (what == "arready") return arready;
    return rvalid;
  endfunction

  // ----------------------------------------------------------------------
  // Checks and bookkeeping
  // ----------------------------------------------------------------------
  task automatic note_error();
    errors++;
    test_errors++;
  endtask

  task automatic check_b(input string name, input axi_sram_pkg::axi_b_t exp_v,
                         input axi_sram_pkg::axi_b_t act);
    if (act !== exp_v) begin
      $display("MISMATCH %s B: expected id=%h resp=%h, actual id=%h resp=%h",
               name, exp_v.id, exp_v.resp, act.id, act.resp);
      note_error();
    end
  endtask

  task automatic check_r(input string name, input axi_sram_pkg::axi_r_t exp_v,
                         input axi_sram_pkg::axi_r_t act);
    if (act !== exp_v) begin
      $display({"MISMATCH %s R: expected id=%h data=%h resp=%h last=%b,",
                " actual id=%h data=%h resp=%h last=%b"},
               name, exp_v.id, exp_v.data, exp_v.resp, exp_v.last,
               act.id, act.data, act.resp, act.last);
      note_error();
    end
  endtask

  // Compares every cycle a response is valid, so stalled payloads are covered too
  always @(negedge aclk) begin
    if (!reset) begin
      if (bvalid) check_b(cur_name, exp_b, b);
      if (rvalid) check_r(cur_name, exp_r, r);
      if (wr_pending && awready) begin
        $display("ERROR %s: awready high before the write response completed", cur_name);
        note_error();
      end
      if (rd_pending && arready) begin
        $display("ERROR %s: arready high before the read data completed", cur_name);
        note_error();
      end
    end
  end

  task automatic start_test(input string name);
    cur_name = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    tests++;
    if (test_errors == 0) begin
      $display("test %s: ok", cur_name);
    end else begin
      failed++;
      $display("test %s: %0d errors", cur_name, test_errors);
    end
  endtask

  // ----------------------------------------------------------------------
  // Drivers, inputs change 2 ns after the rising edge
  // ----------------------------------------------------------------------
  task automatic wait_for(input string what);
    int cnt;
    cnt = 0;
    while (!level_of(what) && cnt < 64) begin
      @(posedge aclk);
      #2;
      cnt++;
    end
    if (!level_of(what)) begin
      $display("ERROR %s: %s did not rise within 64 cycles", cur_name, what);
      note_error();
    end
  endtask

  // Every channel step of the slave takes exactly one cycle
  task automatic check_next_cycle(input string what);
    if (!level_of(what)) begin
      $display("ERROR %s: %s not high one cycle after the previous transfer",
               cur_name, what);
      note_error();
    end
  endtask

  task automatic resp_delay();
    repeat ($unsigned($random(seed)) % 4) begin
      @(posedge aclk);
      #2;
    end
  endtask

  task automatic do_cfg(input axi_sram_pkg::cfg_op_e op, input logic [31:0] data);
    cfg = '{op: op, data: data};
    cfg_stb = 1'b1;
    @(posedge aclk);
    #2;
    cfg_stb = 1'b0;
    if (op == axi_sram_pkg::CFG_SET_BASE) begin
      model_base = data;
    end else begin
      model_en   = data[0];
      model_prot = data[1];
    end
  endtask

  task automatic do_write(input logic [31:0] addr, input logic [63:0] data,
                          input logic [7:0] strb, input logic [3:0] id);
    int idx;
    exp_b = '{id: id, resp: exp_resp(addr, 1'b1)};
    if (exp_b.resp == axi_sram_pkg::RESP_OKAY) begin
      idx = model_index(addr);
      for (int i = 0; i < 8; i++) begin
        if (strb[i]) model_mem[idx][i*8 +: 8] = data[i*8 +: 8];
      end
    end
    aw = '{id: id, addr: addr, len: 8'd0, size: 3'd3, burst: 2'b01};
    awvalid = 1'b1;
    wait_for("awready");
    @(posedge aclk);
    #2;
    awvalid = 1'b0;
    wr_pending = 1'b1;
    w = '{data: data, strb: strb, last: 1'b1};
    wvalid = 1'b1;
    check_next_cycle("wready");
    wait_for("wready");
    @(posedge aclk);
    #2;
    wvalid = 1'b0;
    check_next_cycle("bvalid");
    wait_for("bvalid");
    resp_delay();
    bready = 1'b1;
    @(posedge aclk);
    #2;
    bready = 1'b0;
    wr_pending = 1'b0;
  endtask

  task automatic do_read(input logic [31:0] addr, input logic [3:0] id);
    exp_r = '{id: id, data: exp_rdata(addr), resp: exp_resp(addr, 1'b0), last: 1'b1};
    ar = '{id: id, addr: addr, len: 8'd0, size: 3'd3, burst: 2'b01};
    arvalid = 1'b1;
    wait_for("arready");
    @(posedge aclk);
    #2;
    arvalid = 1'b0;
    rd_pending = 1'b1;
    check_next_cycle("rvalid");
    wait_for("rvalid");
    resp_delay();
    rready = 1'b1;
    @(posedge aclk);
    #2;
    rready = 1'b0;
    rd_pending = 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // Tests
  // ----------------------------------------------------------------------
  initial begin
    int idx;
    seed = 32'h4ab7_bc4f;
    reset = 1'b1;
    cfg_stb = 1'b0;
    cfg = '0;
    aw = '0;
    awvalid = 1'b0;
    w = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    ar = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    model_base = '0;
    model_en = 1'b0;
    model_prot = 1'b0;
    wr_pending = 1'b0;
    rd_pending = 1'b0;
    errors = 0;
    tests = 0;
    failed = 0;
    cur_name = "reset";
    repeat (10) @(posedge aclk);
    #2;
    reset = 1'b0;

    start_test("reset_decerr");
    do_write(32'h0000_0100, rand64(), 8'hff, 4'h3);
    do_read(32'h0000_0100, 4'h5);
    end_test();

    start_test("full_writes");
    do_cfg(axi_sram_pkg::CFG_SET_BASE, 32'h0001_0000);
    do_cfg(axi_sram_pkg::CFG_SET_CTRL, 32'h1);
    repeat (8) begin
      idx = $unsigned($random(seed)) % axi_sram_pkg::MEM_DEPTH;
      written.push_back(idx);
      do_write(word_addr(idx), rand64(), 8'hff, 4'($random(seed)));
    end
    foreach (written[i]) do_read(word_addr(written[i]), 4'($random(seed)));
    end_test();

    start_test("partial_strobe");
    for (int i = 0; i < 4; i++) begin
      do_write(word_addr(written[i]), rand64(), 8'($random(seed)), 4'($random(seed)));
      do_read(word_addr(written[i]), 4'($random(seed)));
    end
    end_test();

    // Edge words first, so the out-of-window accesses have known neighbours
    start_test("window_edges");
    do_write(word_addr(0), rand64(), 8'hff, 4'h1);
    do_write(word_addr(axi_sram_pkg::MEM_DEPTH - 1), rand64(), 8'hff, 4'h2);
    written.push_back(0);
    written.push_back(axi_sram_pkg::MEM_DEPTH - 1);
    do_write(model_base - 8, rand64(), 8'hff, 4'h3);
    do_write(model_base + axi_sram_pkg::WIN_BYTES, rand64(), 8'hff, 4'h4);
    do_read(model_base - 8, 4'h5);
    do_read(model_base + axi_sram_pkg::WIN_BYTES, 4'h6);
    do_read(word_addr(0), 4'h7);
    do_read(word_addr(axi_sram_pkg::MEM_DEPTH - 1), 4'h8);
    end_test();

    start_test("write_protect");
    do_cfg(axi_sram_pkg::CFG_SET_CTRL, 32'h3);
    do_write(word_addr(written[0]), rand64(), 8'hff, 4'h9);
    do_read(word_addr(written[0]), 4'ha);
    do_cfg(axi_sram_pkg::CFG_SET_CTRL, 32'h1);
    end_test();

    // Partial writes only hit fully written words, so no byte stays unknown
    start_test("backpressure");
    repeat (16) begin
      idx = written[$unsigned($random(seed)) % written.size()];
      if ($random(seed) & 1) begin
        do_write(word_addr(idx), rand64(), 8'($random(seed)), 4'($random(seed)));
      end else begin
        do_read(word_addr(idx), 4'($random(seed)));
      end
    end
    end_test();

    $display("%0d tests run, %0d failed, %0d errors", tests, failed, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
axi_sram_pkg.sv
sram_array.sv
axi_sram_window.sv
axi_sram_wr_ctrl.sv
axi_sram_rd_ctrl.sv
axi_sram_top.sv
tb_axi_sram.sv
